/* include/chip8_macros.svh */
// Sizes are tied to the CHIP-8 opcode fields; address width must stay 12 for nnn slicing
`ifndef CHIP8_MACROS_SVH
`define CHIP8_MACROS_SVH

// V register and ALU operand width
`define CHIP8_DATA_W 8

// PC, I and return stack entry width
`define CHIP8_ADDR_W 12

// Register file size
`define CHIP8_NUM_REGS 16

// Bits needed to name one V register
`define CHIP8_REG_IDX_W 4

// VF carries the carry, borrow and shift-out flags
`define CHIP8_FLAG_REG 15

// Return stack entries, pointer wraps modulo this
`define CHIP8_STACK_DEPTH 16

// Programs are loaded at 0x200 by convention
`define CHIP8_PC_RESET 12'h200

// One opcode per instruction word
`define CHIP8_INSTR_W 16

`endif

/* hdl/chip8_pkg.sv */
// Literals carry OP_, ALU_F_ and PC_SRC_ prefixes; refer to them by scoped name, no import
package chip8_pkg;

	// Decoded instruction class, resolved once when an instruction is accepted
	typedef enum logic [4:0] {
		OP_LD_IMM,
		OP_ADD_IMM,
		OP_LD_REG,
		OP_OR,
		OP_AND,
		OP_XOR,
		OP_ADD_REG,
		OP_SUB,
		OP_SHR,
		OP_SUBN,
		OP_SHL,
		OP_JP,
		OP_CALL,
		OP_RET,
		OP_JP_V0,
		OP_SE_IMM,
		OP_SNE_IMM,
		OP_SE_REG,
		OP_SNE_REG,
		OP_LD_I,
		OP_ADD_I,
		OP_NOP
	} chip8_op_e;

	// ALU operation select
	typedef enum logic [2:0] {
		ALU_F_NOP,
		ALU_F_ADD,
		ALU_F_SUB,
		ALU_F_OR,
		ALU_F_AND,
		ALU_F_XOR,
		ALU_F_SHR,
		ALU_F_SHL
	} chip8_alu_f_e;

	// Next PC source: +2, +4, sequencer target, popped return address, unchanged
	typedef enum logic [2:0] {
		PC_SRC_NEXT,
		PC_SRC_SKIP,
		PC_SRC_JUMP,
		PC_SRC_STACK,
		PC_SRC_HOLD
	} chip8_pc_src_e;

endpackage

/* hdl/chip8_alu.sv */
// Purely combinational; flag meaning depends on the function and is 0 for logic ops
`include "chip8_macros.svh"

module chip8_alu (
	input  chip8_pkg::chip8_alu_f_e      alu_f,
	input  logic [`CHIP8_DATA_W-1:0]     a,
	input  logic [`CHIP8_DATA_W-1:0]     b,
	output logic [`CHIP8_DATA_W-1:0]     result,
	output logic                         flag
);

	// One extra bit catches the carry out
	logic [`CHIP8_DATA_W:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		result = '0;
		flag   = 1'b0;
		case (alu_f)
			chip8_pkg::ALU_F_ADD: begin
				result = sum[`CHIP8_DATA_W-1:0];
				flag   = sum[`CHIP8_DATA_W];
			end
			// Flag is set when no borrow occurs, a >= b
			chip8_pkg::ALU_F_SUB: begin
				result = a - b;
				flag   = (a >= b);
			end
			chip8_pkg::ALU_F_OR: result = a | b;
			chip8_pkg::ALU_F_AND: result = a & b;
			chip8_pkg::ALU_F_XOR: result = a ^ b;
			// Shifts act on a only, flag gets the bit shifted out
			chip8_pkg::ALU_F_SHR: begin
				result = a >> 1;
				flag   = a[0];
			end
			chip8_pkg::ALU_F_SHL: begin
				result = a << 1;
				flag   = a[`CHIP8_DATA_W-1];
			end
			default: begin
				result = '0;
				flag   = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/chip8_regfile.sv */
// Reads are combinational with no bypass; port 2 wins when both writes hit one register
`include "chip8_macros.svh"

module chip8_regfile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [`CHIP8_REG_IDX_W-1:0]   rd_addr1,
	input  logic [`CHIP8_REG_IDX_W-1:0]   rd_addr2,
	input  logic [`CHIP8_REG_IDX_W-1:0]   wr_addr1,
	input  logic [`CHIP8_REG_IDX_W-1:0]   wr_addr2,
	input  logic                          wr_en1,
	input  logic                          wr_en2,
	input  logic [`CHIP8_DATA_W-1:0]      wr_data1,
	input  logic [`CHIP8_DATA_W-1:0]      wr_data2,
	input  logic [`CHIP8_REG_IDX_W-1:0]   obs_addr,
	output logic [`CHIP8_DATA_W-1:0]      rdata1,
	output logic [`CHIP8_DATA_W-1:0]      rdata2,
	output logic [`CHIP8_DATA_W-1:0]      obs_data
);

	// V0 to VF
	logic [`CHIP8_DATA_W-1:0] v_regs [`CHIP8_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CHIP8_NUM_REGS; i++)
				v_regs[i] <= '0;
		end else begin
			if (wr_en1)
				v_regs[wr_addr1] <= wr_data1;
			// Last assignment wins, so a VF write overrides Vx when x is F
			if (wr_en2)
				v_regs[wr_addr2] <= wr_data2;
		end
	end

	assign rdata1 = v_regs[rd_addr1];
	assign rdata2 = v_regs[rd_addr2];

	// Third port for inspecting state from outside
	assign obs_data = v_regs[obs_addr];

endmodule

/* hdl/chip8_addr_unit.sv */
// Stack pointer wraps silently on overflow and underflow; no fault is flagged
`include "chip8_macros.svh"

module chip8_addr_unit (
	input  logic                          clk,
	input  logic                          rst,
	input  chip8_pkg::chip8_pc_src_e      pc_src,
	input  logic [`CHIP8_ADDR_W-1:0]      jump_target,
	input  logic                          push,
	input  logic                          pop,
	input  logic                          i_we,
	input  logic [`CHIP8_ADDR_W-1:0]      i_wdata,
	output logic [`CHIP8_ADDR_W-1:0]      pc,
	output logic [`CHIP8_ADDR_W-1:0]      stack_top,
	output logic [`CHIP8_ADDR_W-1:0]      i_reg
);

	localparam int SP_W = $clog2(`CHIP8_STACK_DEPTH);
	localparam logic [SP_W-1:0] SP_LAST = SP_W'(`CHIP8_STACK_DEPTH - 1);

	logic [`CHIP8_ADDR_W-1:0] stack_mem [`CHIP8_STACK_DEPTH];
	logic [SP_W-1:0]          sp;
	logic [SP_W-1:0]          sp_inc;
	logic [SP_W-1:0]          sp_dec;
	logic [`CHIP8_ADDR_W-1:0] pc_plus2;

	// sp points at the next free slot
	assign sp_inc = (sp == SP_LAST) ? '0 : sp + 1'b1;
	assign sp_dec = (sp == '0) ? SP_LAST : sp - 1'b1;

	assign stack_top = stack_mem[sp_dec];
	assign pc_plus2  = pc + `CHIP8_ADDR_W'(2);

	// Program counter
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CHIP8_PC_RESET;
		end else begin
			case (pc_src)
				chip8_pkg::PC_SRC_NEXT:  pc <= pc_plus2;
				chip8_pkg::PC_SRC_SKIP:  pc <= pc + `CHIP8_ADDR_W'(4);
				chip8_pkg::PC_SRC_JUMP:  pc <= jump_target;
				chip8_pkg::PC_SRC_STACK: pc <= stack_top;
				default:                 pc <= pc;
			endcase
		end
	end

	// Stack pointer
	always_ff @(posedge clk) begin
		if (rst)
			sp <= '0;
		else if (push)
			sp <= sp_inc;
		else if (pop)
			sp <= sp_dec;
	end

	// Return address is the instruction after the call
	always_ff @(posedge clk) begin
		if (push)
			stack_mem[sp] <= pc_plus2;
	end

	// Index register
	always_ff @(posedge clk) begin
		if (rst)
			i_reg <= '0;
		else if (i_we)
			i_reg <= i_wdata;
	end

endmodule

/* hdl/chip8_sequencer.sv */
// One instruction in flight; instr_valid is ignored unless ready, unknown opcodes act as NOP
`include "chip8_macros.svh"

module chip8_sequencer (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          instr_valid,
	input  logic [`CHIP8_INSTR_W-1:0]     instruction,
	input  logic [`CHIP8_DATA_W-1:0]      rdata1,
	input  logic [`CHIP8_DATA_W-1:0]      rdata2,
	input  logic [`CHIP8_DATA_W-1:0]      alu_result,
	input  logic                          alu_flag,
	input  logic [`CHIP8_ADDR_W-1:0]      pc,
	input  logic [`CHIP8_ADDR_W-1:0]      i_reg,
	input  logic [`CHIP8_ADDR_W-1:0]      stack_top,
	output logic                          ready,
	output logic [`CHIP8_REG_IDX_W-1:0]   rd_addr1,
	output logic [`CHIP8_REG_IDX_W-1:0]   rd_addr2,
	output logic                          wr_en1,
	output logic                          wr_en2,
	output logic [`CHIP8_REG_IDX_W-1:0]   wr_addr1,
	output logic [`CHIP8_REG_IDX_W-1:0]   wr_addr2,
	output logic [`CHIP8_DATA_W-1:0]      wr_data1,
	output logic [`CHIP8_DATA_W-1:0]      wr_data2,
	output chip8_pkg::chip8_alu_f_e       alu_f,
	output logic [`CHIP8_DATA_W-1:0]      alu_a,
	output logic [`CHIP8_DATA_W-1:0]      alu_b,
	output chip8_pkg::chip8_pc_src_e      pc_src,
	output logic [`CHIP8_ADDR_W-1:0]      jump_target,
	output logic                          push,
	output logic                          pop,
	output logic                          i_we,
	output logic [`CHIP8_ADDR_W-1:0]      i_wdata
);

	localparam int ZEXT_W = `CHIP8_ADDR_W - `CHIP8_DATA_W;
	localparam logic [`CHIP8_REG_IDX_W-1:0] FLAG_IDX = `CHIP8_FLAG_REG;

	// Idle, register read, execute and writeback
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_EXEC
	} stage_e;

	stage_e                          stage;
	chip8_pkg::chip8_op_e            op_reg;
	logic [`CHIP8_INSTR_W-1:0]       instr_reg;
	logic [`CHIP8_REG_IDX_W-1:0]     x_idx;
	logic [`CHIP8_REG_IDX_W-1:0]     y_idx;
	logic [`CHIP8_DATA_W-1:0]        kk;
	logic [`CHIP8_ADDR_W-1:0]        nnn;
	logic [`CHIP8_DATA_W-1:0]        vf_data;

	// Map an opcode word onto the kept instruction set
	function automatic chip8_pkg::chip8_op_e decode_op(input logic [`CHIP8_INSTR_W-1:0] ins);
		chip8_pkg::chip8_op_e op;
		op = chip8_pkg::OP_NOP;
		case (ins[15:12])
			4'h0: if (ins == 16'h00EE) op = chip8_pkg::OP_RET;
			4'h1: op = chip8_pkg::OP_JP;
			4'h2: op = chip8_pkg::OP_CALL;
			4'h3: op = chip8_pkg::OP_SE_IMM;
			4'h4: op = chip8_pkg::OP_SNE_IMM;
			4'h5: if (ins[3:0] == 4'h0) op = chip8_pkg::OP_SE_REG;
			4'h6: op = chip8_pkg::OP_LD_IMM;
			4'h7: op = chip8_pkg::OP_ADD_IMM;
			4'h8: begin
				case (ins[3:0])
					4'h0: op = chip8_pkg::OP_LD_REG;
					4'h1: op = chip8_pkg::OP_OR;
					4'h2: op = chip8_pkg::OP_AND;
					4'h3: op = chip8_pkg::OP_XOR;
					4'h4: op = chip8_pkg::OP_ADD_REG;
					4'h5: op = chip8_pkg::OP_SUB;
					4'h6: op = chip8_pkg::OP_SHR;
					4'h7: op = chip8_pkg::OP_SUBN;
					4'hE: op = chip8_pkg::OP_SHL;
					default: op = chip8_pkg::OP_NOP;
				endcase
			end
			4'h9: if (ins[3:0] == 4'h0) op = chip8_pkg::OP_SNE_REG;
			4'hA: op = chip8_pkg::OP_LD_I;
			4'hB: op = chip8_pkg::OP_JP_V0;
			4'hF: if (ins[7:0] == 8'h1E) op = chip8_pkg::OP_ADD_I;
			default: op = chip8_pkg::OP_NOP;
		endcase
		return op;
	endfunction

	// Accept only while idle
	assign ready = (stage == ST_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			stage  <= ST_IDLE;
			op_reg <= chip8_pkg::OP_NOP;
		end else begin
			case (stage)
				ST_IDLE: begin
					if (instr_valid) begin
						stage  <= ST_READ;
						op_reg <= decode_op(instruction);
					end
				end
				ST_READ: stage <= ST_EXEC;
				default: stage <= ST_IDLE;
			endcase
		end
	end

	// Operand fields come from this copy while the instruction runs
	always_ff @(posedge clk) begin
		if (ready && instr_valid)
			instr_reg <= instruction;
	end

	assign x_idx   = instr_reg[11:8];
	assign y_idx   = instr_reg[7:4];
	assign kk      = instr_reg[7:0];
	assign nnn     = instr_reg[11:0];
	assign vf_data = {{(`CHIP8_DATA_W-1){1'b0}}, alu_flag};

	always_comb begin
		rd_addr1    = '0;
		rd_addr2    = '0;
		wr_en1      = 1'b0;
		wr_en2      = 1'b0;
		wr_addr1    = x_idx;
		wr_addr2    = FLAG_IDX;
		wr_data1    = alu_result;
		wr_data2    = vf_data;
		alu_f       = chip8_pkg::ALU_F_NOP;
		alu_a       = rdata1;
		alu_b       = rdata2;
		pc_src      = chip8_pkg::PC_SRC_HOLD;
		// Target bus idles at the fall-through address
		jump_target = pc + `CHIP8_ADDR_W'(2);
		push        = 1'b0;
		pop         = 1'b0;
		i_we        = 1'b0;
		i_wdata     = nnn;

		// Read addresses stay up through both stages so stage 2 sees settled data
		if (stage != ST_IDLE) begin
			rd_addr1 = (op_reg == chip8_pkg::OP_JP_V0) ? '0 : x_idx;
			rd_addr2 = y_idx;
		end

		if (stage == ST_EXEC) begin
			pc_src = chip8_pkg::PC_SRC_NEXT;
			case (op_reg)
				chip8_pkg::OP_LD_IMM: begin
					wr_en1   = 1'b1;
					wr_data1 = kk;
				end
				// Immediate add leaves VF alone
				chip8_pkg::OP_ADD_IMM: begin
					alu_f  = chip8_pkg::ALU_F_ADD;
					alu_b  = kk;
					wr_en1 = 1'b1;
				end
				chip8_pkg::OP_LD_REG: begin
					wr_en1   = 1'b1;
					wr_data1 = rdata2;
				end
				chip8_pkg::OP_OR: begin
					alu_f  = chip8_pkg::ALU_F_OR;
					wr_en1 = 1'b1;
				end
				chip8_pkg::OP_AND: begin
					alu_f  = chip8_pkg::ALU_F_AND;
					wr_en1 = 1'b1;
				end
				chip8_pkg::OP_XOR: begin
					alu_f  = chip8_pkg::ALU_F_XOR;
					wr_en1 = 1'b1;
				end
				// Flagged ops write Vx on port 1 and VF on port 2
				chip8_pkg::OP_ADD_REG: begin
					alu_f  = chip8_pkg::ALU_F_ADD;
					wr_en1 = 1'b1;
					wr_en2 = 1'b1;
				end
				chip8_pkg::OP_SUB: begin
					alu_f  = chip8_pkg::ALU_F_SUB;
					wr_en1 = 1'b1;
					wr_en2 = 1'b1;
				end
				// Operands swapped, Vy - Vx
				chip8_pkg::OP_SUBN: begin
					alu_f  = chip8_pkg::ALU_F_SUB;
					alu_a  = rdata2;
					alu_b  = rdata1;
					wr_en1 = 1'b1;
					wr_en2 = 1'b1;
				end
				chip8_pkg::OP_SHR: begin
					alu_f  = chip8_pkg::ALU_F_SHR;
					wr_en1 = 1'b1;
					wr_en2 = 1'b1;
				end
				chip8_pkg::OP_SHL: begin
					alu_f  = chip8_pkg::ALU_F_SHL;
					wr_en1 = 1'b1;
					wr_en2 = 1'b1;
				end
				chip8_pkg::OP_JP: begin
					pc_src      = chip8_pkg::PC_SRC_JUMP;
					jump_target = nnn;
				end
				// Address unit pushes PC+2 itself
				chip8_pkg::OP_CALL: begin
					push        = 1'b1;
					pc_src      = chip8_pkg::PC_SRC_JUMP;
					jump_target = nnn;
				end
				chip8_pkg::OP_RET: begin
					pop         = 1'b1;
					pc_src      = chip8_pkg::PC_SRC_STACK;
					jump_target = stack_top;
				end
				// Port 1 reads V0 here, sum wraps at 12 bits
				chip8_pkg::OP_JP_V0: begin
					pc_src      = chip8_pkg::PC_SRC_JUMP;
					jump_target = nnn + {{ZEXT_W{1'b0}}, rdata1};
				end
				chip8_pkg::OP_SE_IMM: begin
					if (rdata1 == kk)
						pc_src = chip8_pkg::PC_SRC_SKIP;
				end
				chip8_pkg::OP_SNE_IMM: begin
					if (rdata1 != kk)
						pc_src = chip8_pkg::PC_SRC_SKIP;
				end
				chip8_pkg::OP_SE_REG: begin
					if (rdata1 == rdata2)
						pc_src = chip8_pkg::PC_SRC_SKIP;
				end
				chip8_pkg::OP_SNE_REG: begin
					if (rdata1 != rdata2)
						pc_src = chip8_pkg::PC_SRC_SKIP;
				end
				chip8_pkg::OP_LD_I: begin
					i_we = 1'b1;
				end
				chip8_pkg::OP_ADD_I: begin
					i_we    = 1'b1;
					i_wdata = i_reg + {{ZEXT_W{1'b0}}, rdata1};
				end
				default: begin
					// NOP, PC just advances
				end
			endcase
		end
	end

endmodule

/* hdl/chip8_core.sv */
// Executes one supplied instruction at a time; no fetch memory, PC is only reported
`include "chip8_macros.svh"

module chip8_core (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          instr_valid,
	input  logic [`CHIP8_INSTR_W-1:0]     instruction,
	input  logic [`CHIP8_REG_IDX_W-1:0]   obs_addr,
	output logic                          ready,
	output logic [`CHIP8_ADDR_W-1:0]      pc,
	output logic [`CHIP8_ADDR_W-1:0]      i_reg,
	output logic [`CHIP8_DATA_W-1:0]      obs_data
);

	// Register file
	logic [`CHIP8_REG_IDX_W-1:0] rd_addr1;
	logic [`CHIP8_REG_IDX_W-1:0] rd_addr2;
	logic [`CHIP8_REG_IDX_W-1:0] wr_addr1;
	logic [`CHIP8_REG_IDX_W-1:0] wr_addr2;
	logic                        wr_en1;
	logic                        wr_en2;
	logic [`CHIP8_DATA_W-1:0]    wr_data1;
	logic [`CHIP8_DATA_W-1:0]    wr_data2;
	logic [`CHIP8_DATA_W-1:0]    rdata1;
	logic [`CHIP8_DATA_W-1:0]    rdata2;

	// ALU
	chip8_pkg::chip8_alu_f_e     alu_f;
	logic [`CHIP8_DATA_W-1:0]    alu_a;
	logic [`CHIP8_DATA_W-1:0]    alu_b;
	logic [`CHIP8_DATA_W-1:0]    alu_result;
	logic                        alu_flag;

	// Address unit
	chip8_pkg::chip8_pc_src_e    pc_src;
	logic [`CHIP8_ADDR_W-1:0]    jump_target;
	logic [`CHIP8_ADDR_W-1:0]    stack_top;
	logic [`CHIP8_ADDR_W-1:0]    i_wdata;
	logic                        push;
	logic                        pop;
	logic                        i_we;

	chip8_sequencer chip8_sequencer_i (
		.clk, .rst, .instr_valid, .instruction,
		.rdata1, .rdata2, .alu_result, .alu_flag,
		.pc, .i_reg, .stack_top,
		.ready,
		.rd_addr1, .rd_addr2,
		.wr_en1, .wr_en2, .wr_addr1, .wr_addr2, .wr_data1, .wr_data2,
		.alu_f, .alu_a, .alu_b,
		.pc_src, .jump_target, .push, .pop,
		.i_we, .i_wdata
	);

	chip8_alu chip8_alu_i (
		.alu_f,
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result),
		.flag   (alu_flag)
	);

	chip8_regfile chip8_regfile_i (
		.clk, .rst,
		.rd_addr1, .rd_addr2, .wr_addr1, .wr_addr2,
		.wr_en1, .wr_en2, .wr_data1, .wr_data2,
		.obs_addr,
		.rdata1, .rdata2, .obs_data
	);

	chip8_addr_unit chip8_addr_unit_i (
		.clk, .rst,
		.pc_src, .jump_target, .push, .pop,
		.i_we, .i_wdata,
		.pc, .stack_top, .i_reg
	);

endmodule

/* verif/chip8_core_tb.sv */
// Rows run in order from reset and each expected value assumes every earlier row has executed
`include "chip8_macros.svh"

module chip8_core_tb;

	localparam int CLK_HALF     = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_ROWS     = 64;

	logic                          clk;
	logic                          rst;
	logic                          instr_valid;
	logic [`CHIP8_INSTR_W-1:0]     instruction;
	logic [`CHIP8_REG_IDX_W-1:0]   obs_addr;
	logic                          ready;
	logic [`CHIP8_ADDR_W-1:0]      pc;
	logic [`CHIP8_ADDR_W-1:0]      i_reg;
	logic [`CHIP8_DATA_W-1:0]      obs_data;

	// Stimulus table, one instruction and its expected state per row
	logic [`CHIP8_INSTR_W-1:0]     row_instr [MAX_ROWS];
	logic [`CHIP8_ADDR_W-1:0]      row_pc    [MAX_ROWS];
	logic [`CHIP8_ADDR_W-1:0]      row_i     [MAX_ROWS];
	logic [`CHIP8_REG_IDX_W-1:0]   row_reg   [MAX_ROWS];
	logic [`CHIP8_DATA_W-1:0]      row_val   [MAX_ROWS];

	int num_rows    = 0;
	int error_count = 0;
	int failed_rows = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	chip8_core chip8_core_i (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instruction (instruction),
		.obs_addr    (obs_addr),
		.ready       (ready),
		.pc          (pc),
		.i_reg       (i_reg),
		.obs_data    (obs_data)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Watchdog, limit is set from the table length before the first edge
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run timed out waiting for ready after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic add_row(input logic [15:0] ins, input logic [11:0] exp_pc,
			input logic [11:0] exp_i, input logic [3:0] reg_idx, input logic [7:0] exp_val);
		row_instr[num_rows] = ins;
		row_pc[num_rows]    = exp_pc;
		row_i[num_rows]     = exp_i;
		row_reg[num_rows]   = reg_idx;
		row_val[num_rows]   = exp_val;
		num_rows++;
	endtask

	task automatic build_table();
		// Immediate loads, 7xkk wraps and keeps VF
		add_row(16'h6A05, 12'h202, 12'h000, 4'hA, 8'h05);
		add_row(16'h6B03, 12'h204, 12'h000, 4'hB, 8'h03);
		add_row(16'h6F01, 12'h206, 12'h000, 4'hF, 8'h01);
		add_row(16'h7AFF, 12'h208, 12'h000, 4'hA, 8'h04);
		add_row(16'h7B00, 12'h20A, 12'h000, 4'hF, 8'h01);
		// Register copy and logic ops into VC
		add_row(16'h8CA0, 12'h20C, 12'h000, 4'hC, 8'h04);
		add_row(16'h8CB1, 12'h20E, 12'h000, 4'hC, 8'h07);
		add_row(16'h8CA2, 12'h210, 12'h000, 4'hC, 8'h04);
		add_row(16'h8CB3, 12'h212, 12'h000, 4'hC, 8'h07);
		// ADD without and with carry, 7000 rows only read back another register
		add_row(16'h6DF0, 12'h214, 12'h000, 4'hD, 8'hF0);
		add_row(16'h8DA4, 12'h216, 12'h000, 4'hD, 8'hF4);
		add_row(16'h7000, 12'h218, 12'h000, 4'hF, 8'h00);
		add_row(16'h8DD4, 12'h21A, 12'h000, 4'hF, 8'h01);
		add_row(16'h7000, 12'h21C, 12'h000, 4'hD, 8'hE8);
		// SUB no borrow, then borrow
		add_row(16'h8AB5, 12'h21E, 12'h000, 4'hA, 8'h01);
		add_row(16'h7000, 12'h220, 12'h000, 4'hF, 8'h01);
		add_row(16'h8AB5, 12'h222, 12'h000, 4'hF, 8'h00);
		add_row(16'h7000, 12'h224, 12'h000, 4'hA, 8'hFE);
		// SUBN with borrow, then without
		add_row(16'h8AB7, 12'h226, 12'h000, 4'hA, 8'h05);
		add_row(16'h7000, 12'h228, 12'h000, 4'hF, 8'h00);
		add_row(16'h8BA7, 12'h22A, 12'h000, 4'hF, 8'h01);
		// Shifts, VF gets the bit shifted out
		add_row(16'h8DA6, 12'h22C, 12'h000, 4'hD, 8'h74);
		add_row(16'h7000, 12'h22E, 12'h000, 4'hF, 8'h00);
		add_row(16'h8C06, 12'h230, 12'h000, 4'hF, 8'h01);
		add_row(16'h8D0E, 12'h232, 12'h000, 4'hD, 8'hE8);
		add_row(16'h8D0E, 12'h234, 12'h000, 4'hF, 8'h01);
		// x is F, flag write beats the sum
		add_row(16'h8FA4, 12'h236, 12'h000, 4'hF, 8'h00);
		// Skips taken and not taken
		add_row(16'h3A05, 12'h23A, 12'h000, 4'hA, 8'h05);
		add_row(16'h3A06, 12'h23C, 12'h000, 4'hA, 8'h05);
		add_row(16'h4A06, 12'h240, 12'h000, 4'hA, 8'h05);
		add_row(16'h4A05, 12'h242, 12'h000, 4'hA, 8'h05);
		add_row(16'h5AB0, 12'h244, 12'h000, 4'hB, 8'h02);
		add_row(16'h6B05, 12'h246, 12'h000, 4'hB, 8'h05);
		add_row(16'h5AB0, 12'h24A, 12'h000, 4'hB, 8'h05);
		add_row(16'h9AB0, 12'h24C, 12'h000, 4'hB, 8'h05);
		add_row(16'h9AC0, 12'h250, 12'h000, 4'hC, 8'h03);
		// Jump, two nested calls and their returns
		add_row(16'h1400, 12'h400, 12'h000, 4'h0, 8'h00);
		add_row(16'h2600, 12'h600, 12'h000, 4'h0, 8'h00);
		add_row(16'h2800, 12'h800, 12'h000, 4'h0, 8'h00);
		add_row(16'h00EE, 12'h602, 12'h000, 4'h0, 8'h00);
		add_row(16'h00EE, 12'h402, 12'h000, 4'h0, 8'h00);
		// Bnnn lands on nnn + V0
		add_row(16'h6010, 12'h404, 12'h000, 4'h0, 8'h10);
		add_row(16'hB300, 12'h310, 12'h000, 4'h0, 8'h10);
		// Index loads and adds, the last one wraps at 12 bits
		add_row(16'hA123, 12'h312, 12'h123, 4'hA, 8'h05);
		add_row(16'hFA1E, 12'h314, 12'h128, 4'hA, 8'h05);
		add_row(16'hAFFE, 12'h316, 12'hFFE, 4'hD, 8'hD0);
		add_row(16'hFD1E, 12'h318, 12'h0CE, 4'hD, 8'hD0);
		// Unsupported opcodes only advance PC
		add_row(16'hE09E, 12'h31A, 12'h0CE, 4'hA, 8'h05);
		add_row(16'h8AB8, 12'h31C, 12'h0CE, 4'hA, 8'h05);
		add_row(16'h00E0, 12'h31E, 12'h0CE, 4'hA, 8'h05);
	endtask

	task automatic expect_equal(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	// Called at a drive point, polls one cycle at a time
	task automatic wait_ready();
		while (ready !== 1'b1) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic apply_row(input int idx);
		int errors_before;
		errors_before = error_count;
		wait_ready();
		instruction = row_instr[idx];
		instr_valid = 1'b1;
		obs_addr    = row_reg[idx];
		// Accept edge
		@(posedge clk);
		#DRIVE_DELAY;
		instr_valid = 1'b0;
		expect_equal("ready in stage 1", ready, 16'h0);
		@(posedge clk);
		#DRIVE_DELAY;
		expect_equal("ready in stage 2", ready, 16'h0);
		// Writeback edge, results visible now
		@(posedge clk);
		#DRIVE_DELAY;
		expect_equal("ready after writeback", ready, 16'h1);
		expect_equal("pc", pc, row_pc[idx]);
		expect_equal("i_reg", i_reg, row_i[idx]);
		expect_equal($sformatf("V%h", row_reg[idx]), obs_data, row_val[idx]);
		if (error_count == errors_before) begin
			$display("row %0d instr %h: ok", idx, row_instr[idx]);
		end else begin
			failed_rows++;
			$display("row %0d instr %h: %0d errors", idx, row_instr[idx],
				error_count - errors_before);
		end
	endtask

	// obs_addr has selected V0 since time 0 and outputs settled at the last reset edge
	task automatic check_reset_state();
		expect_equal("ready after reset", ready, 16'h1);
		expect_equal("pc after reset", pc, `CHIP8_PC_RESET);
		expect_equal("i_reg after reset", i_reg, 16'h0);
		expect_equal("V0 after reset", obs_data, 16'h0);
		$display("reset state: %0d errors", error_count);
	endtask

	initial begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instruction = '0;
		obs_addr    = '0;
		build_table();
		cycle_limit = RESET_CYCLES + num_rows * 4 + 50;

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		check_reset_state();

		for (int r = 0; r < num_rows; r++)
			apply_row(r);

		$display("%0d rows, %0d rows failed, %0d errors", num_rows, failed_rows, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+include
hdl/chip8_pkg.sv
hdl/chip8_alu.sv
hdl/chip8_regfile.sv
hdl/chip8_addr_unit.sv
hdl/chip8_sequencer.sv
hdl/chip8_core.sv
verif/chip8_core_tb.sv

/* Bender.yml */
package:
  name: chip8_core

export_include_dirs:
  - include

sources:
  - files:
      - hdl/chip8_pkg.sv
      - hdl/chip8_alu.sv
      - hdl/chip8_regfile.sv
      - hdl/chip8_addr_unit.sv
      - hdl/chip8_sequencer.sv
      - hdl/chip8_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/chip8_core_tb.sv
